// File: verilog/pipe_pkg.sv
// Shared definitions for the pipeline-control subsystem
//   word and address types
//   instruction kind enum and its decode function
//   request struct carried by the data and extension ports
package pipe_pkg;

   // Instruction or data word
   typedef logic [31:0] word_t;

   // Word address, byte offset dropped
   typedef logic [29:0] addr_t;

   // Kind taken from the top two bits of the word
   typedef enum logic [1:0] {
      KIND_NOP  = 2'b00,
      KIND_DATA = 2'b01,
      KIND_EXT  = 2'b10,
      KIND_SKIP = 2'b11
   } kind_e;

   // One request held on a data or extension port
   // Fields fill the word from the top down
   typedef struct packed {
      // Word bits 29:0 of the instruction
      addr_t adr;
      // Thread phase sampled at the take
      logic  tid;
      // Always zero
      logic  spare;
   } bus_req_t;

   // Decode of the instruction kind
   // SKIP is passed through, the issue stage treats it as NOP
   function automatic kind_e kind_of(input word_t w);
      kind_e k;
      k = kind_e'(w[31:30]);
      return k;
   endfunction

endpackage

// File: verilog/pipe_ctrl.sv
`timescale 1ns/10ps
// Pipeline controller
//   two-clock reset delay producing grst
//   instruction-side and data-side enables from unit feedback
//   thread phase flip-flop
module pipe_ctrl (
   input  logic sys_clk_i,
   input  logic sys_rst_i,
   input  logic sys_ena_i,
   input  logic fet_fb_i,
   input  logic ich_fb_i,
   input  logic dwb_fb_i,
   input  logic xwb_fb_i,
   output logic grst_o,
   output logic gpha_o,
   output logic iena_o,
   output logic dena_o
);

   // Reset delay stages
   logic [1:0] rst_dly;

   // Ones shift in once reset is released
   always_ff @(posedge sys_clk_i) begin
      if (sys_rst_i) begin
         rst_dly <= 2'b00;
      end else begin
         rst_dly <= {rst_dly[0], 1'b1};
      end
   end

   // Held until a one reaches the last stage
   assign grst_o = ~rst_dly[1];

   // Instruction side runs with no fetch pending and both ports idle
   assign iena_o = fet_fb_i & xwb_fb_i & dwb_fb_i & sys_ena_i;

   // Data side also needs a word waiting in the fetch buffer
   assign dena_o = dwb_fb_i & xwb_fb_i & ich_fb_i & sys_ena_i;

   // Phase flips per taken word and per grst clock
   // Two grst clocks bring it back to 0 before the first take
   always_ff @(posedge sys_clk_i) begin
      if (sys_rst_i) begin
         gpha_o <= 1'b0;
      end else if (dena_o | grst_o) begin
         gpha_o <= ~gpha_o;
      end
   end

   // Fetch buffer is held empty while grst is high
   a_no_dena_in_grst: assert property (
      @(posedge sys_clk_i) disable iff (sys_rst_i) grst_o |-> !dena_o);

   // A take empties the buffer, so takes are never back to back
   a_dena_not_twice: assert property (
      @(posedge sys_clk_i) disable iff (sys_rst_i) dena_o |=> !dena_o);

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/10ps
// Fetch unit
//   program counter loaded during grst
//   instruction-bus strobe held until acknowledge
//   one-entry fetch buffer emptied by the data-side enable
module fetch_unit #(
   parameter pipe_pkg::addr_t RESET_ADDR = '0
) (
   input  logic            sys_clk_i,
   input  logic            grst_i,
   input  logic            dena_i,
   input  logic            iwb_ack_i,
   input  pipe_pkg::word_t iwb_dat_i,
   output logic            iwb_stb_o,
   output pipe_pkg::addr_t iwb_adr_o,
   output logic            fet_fb_o,
   output logic            ich_fb_o,
   output pipe_pkg::word_t buf_o
);

   // Program counter, word granular
   pipe_pkg::addr_t pc_q;
   // Buffer word and its valid flag
   pipe_pkg::word_t buf_q;
   logic            buf_vld_q;
   // Pending instruction-bus request
   logic            stb_q;
   // Acknowledge of the pending request
   logic            fetch_done;
   // Buffer has room now or frees up this clock
   logic            slot_free;

   assign fetch_done = stb_q & iwb_ack_i;
   assign slot_free  = ~buf_vld_q | dena_i;

   // Strobe rises once a slot is free, drops on the ack
   always_ff @(posedge sys_clk_i) begin
      if (grst_i) begin
         stb_q <= 1'b0;
      end else if (fetch_done) begin
         stb_q <= 1'b0;
      end else if (~stb_q & slot_free) begin
         stb_q <= 1'b1;
      end
   end

   // PC steps one word per acknowledged fetch
   always_ff @(posedge sys_clk_i) begin
      if (grst_i) begin
         pc_q <= RESET_ADDR;
      end else if (fetch_done) begin
         pc_q <= pc_q + 30'd1;
      end
   end

   // Fill on the ack, empty when the issue stage takes the word
   // Fill and take never meet, a fetch only runs into an empty slot
   always_ff @(posedge sys_clk_i) begin
      if (grst_i) begin
         buf_vld_q <= 1'b0;
      end else if (fetch_done) begin
         buf_vld_q <= 1'b1;
      end else if (dena_i) begin
         buf_vld_q <= 1'b0;
      end
   end

   // Word sampled with the ack
   always_ff @(posedge sys_clk_i) begin
      if (fetch_done) begin
         buf_q <= iwb_dat_i;
      end
   end

   assign iwb_stb_o = stb_q;
   assign iwb_adr_o = pc_q;
   // No request outstanding
   assign fet_fb_o  = ~stb_q;
   assign ich_fb_o  = buf_vld_q;
   assign buf_o     = buf_q;

endmodule

// File: verilog/issue_stage.sv
`timescale 1ns/10ps
// Issue stage
//   issue register loaded from the fetch buffer on dena
//   phase capture for the request thread id
//   kind decode and one-clock load strobe to the data or extension port
module issue_stage (
   input  logic               sys_clk_i,
   input  logic               grst_i,
   input  logic               dena_i,
   input  logic               gpha_i,
   input  pipe_pkg::word_t    buf_i,
   output logic               dreq_stb_o,
   output logic               xreq_stb_o,
   output pipe_pkg::bus_req_t req_o
);

   // Issued word and the phase seen at the take
   pipe_pkg::word_t ins_q;
   logic            tid_q;
   // High for the one clock after a take
   logic            take_q;
   // Kind of the issued word
   pipe_pkg::kind_e kind;

   // Take marker, cleared while grst holds the front end
   always_ff @(posedge sys_clk_i) begin
      if (grst_i) begin
         take_q <= 1'b0;
      end else begin
         take_q <= dena_i;
      end
   end

   // Issue register
   always_ff @(posedge sys_clk_i) begin
      if (dena_i) begin
         ins_q <= buf_i;
         tid_q <= gpha_i;
      end
   end

   assign kind = pipe_pkg::kind_of(ins_q);

   // Load pulse to the matching port
   // NOP and SKIP words still toggle the phase but launch nothing
   always_comb begin
      dreq_stb_o = 1'b0;
      xreq_stb_o = 1'b0;
      if (take_q) begin
         case (kind)
            pipe_pkg::KIND_DATA: dreq_stb_o = 1'b1;
            pipe_pkg::KIND_EXT:  xreq_stb_o = 1'b1;
            default: begin
               dreq_stb_o = 1'b0;
               xreq_stb_o = 1'b0;
            end
         endcase
      end
   end

   // Request built from the low word bits and the take phase
   always_comb begin
      req_o       = '0;
      req_o.adr   = ins_q[29:0];
      req_o.tid   = tid_q;
      req_o.spare = 1'b0;
   end

endmodule

// File: verilog/bus_port.sv
`timescale 1ns/10ps
// Bus port
//   latches one request on a load pulse
//   holds strobe and request until the acknowledge
//   idle flag fed back to the controller
module bus_port (
   input  logic               sys_clk_i,
   input  logic               grst_i,
   input  logic               load_i,
   input  pipe_pkg::bus_req_t req_i,
   input  logic               ack_i,
   output logic               stb_o,
   output pipe_pkg::bus_req_t req_o,
   output logic               idle_o
);

   // Outstanding request flag and its payload
   logic               stb_q;
   pipe_pkg::bus_req_t req_q;

   // Raised by the load, dropped by the ack
   always_ff @(posedge sys_clk_i) begin
      if (grst_i) begin
         stb_q <= 1'b0;
      end else if (load_i) begin
         stb_q <= 1'b1;
      end else if (stb_q & ack_i) begin
         stb_q <= 1'b0;
      end
   end

   // Payload only moves on a load
   always_ff @(posedge sys_clk_i) begin
      if (load_i) begin
         req_q <= req_i;
      end
   end

   assign stb_o  = stb_q;
   assign req_o  = req_q;
   assign idle_o = ~stb_q;

   // Controller must hold off dena while this port is busy
   a_no_load_busy: assert property (
      @(posedge sys_clk_i) disable iff (grst_i) load_i |-> !stb_q);

endmodule

// File: verilog/pipe_top.sv
`timescale 1ns/10ps
// Pipeline-control top level
//   controller with reset delay, enables and phase
//   fetch unit on the instruction bus
//   issue stage feeding the data and extension ports
module pipe_top #(
   parameter pipe_pkg::addr_t RESET_ADDR = '0
) (
   input  logic               sys_clk_i,
   input  logic               sys_rst_i,
   input  logic               sys_ena_i,
   // Instruction bus
   output logic               iwb_stb_o,
   output pipe_pkg::addr_t    iwb_adr_o,
   input  logic               iwb_ack_i,
   input  pipe_pkg::word_t    iwb_dat_i,
   // Data bus
   output logic               dwb_stb_o,
   output pipe_pkg::bus_req_t dwb_req_o,
   input  logic               dwb_ack_i,
   // Extension bus
   output logic               xwb_stb_o,
   output pipe_pkg::bus_req_t xwb_req_o,
   input  logic               xwb_ack_i,
   output logic               gpha_o
);

   logic               grst;
   logic               gpha;
   logic               dena;
   // Unit feedback levels
   logic               fet_fb;
   logic               ich_fb;
   logic               dwb_fb;
   logic               xwb_fb;
   // Fetch buffer to issue stage
   pipe_pkg::word_t    buf_word;
   // Issue stage to the two ports
   logic               dreq_stb;
   logic               xreq_stb;
   pipe_pkg::bus_req_t issue_req;

   // Instruction-side enable has no consumer, fetch paces itself on the ack
   pipe_ctrl ctrl_i (
      .sys_clk_i, .sys_rst_i, .sys_ena_i,
      .fet_fb_i (fet_fb), .ich_fb_i (ich_fb), .dwb_fb_i (dwb_fb), .xwb_fb_i (xwb_fb),
      .grst_o (grst), .gpha_o (gpha), .iena_o (), .dena_o (dena)
   );

   fetch_unit #(.RESET_ADDR (RESET_ADDR)) fetch_i (
      .sys_clk_i, .grst_i (grst), .dena_i (dena),
      .iwb_ack_i, .iwb_dat_i, .iwb_stb_o, .iwb_adr_o,
      .fet_fb_o (fet_fb), .ich_fb_o (ich_fb), .buf_o (buf_word)
   );

   issue_stage issue_i (
      .sys_clk_i, .grst_i (grst), .dena_i (dena), .gpha_i (gpha), .buf_i (buf_word),
      .dreq_stb_o (dreq_stb), .xreq_stb_o (xreq_stb), .req_o (issue_req)
   );

   // Data and extension ports share one design
   bus_port dwb_i (
      .sys_clk_i, .grst_i (grst), .load_i (dreq_stb), .req_i (issue_req),
      .ack_i (dwb_ack_i), .stb_o (dwb_stb_o), .req_o (dwb_req_o), .idle_o (dwb_fb)
   );

   bus_port xwb_i (
      .sys_clk_i, .grst_i (grst), .load_i (xreq_stb), .req_i (issue_req),
      .ack_i (xwb_ack_i), .stb_o (xwb_stb_o), .req_o (xwb_req_o), .idle_o (xwb_fb)
   );

   assign gpha_o = gpha;

endmodule

// File: verif/pipe_top_tb.sv
`timescale 1ns/10ps
// Testbench for the pipeline-control top level
//   stimulus table of words, fetch delays, bus delays and stall flags
//   instruction, data and extension bus responders
//   scoreboard for routing, address and thread phase
//   reset, back-pressure and stall checks with a cycle-limit timeout
module pipe_top_tb;

   localparam int N = 16;
   localparam int STALL_CYCLES = 4;
   localparam pipe_pkg::addr_t RESET_ADDR = 30'h0000_1000;
   // Kind per row, 01 data, 10 extension, 00 nop, 11 skip
   localparam logic [1:0] KINDS [N] = '{2'b01, 2'b10, 2'b00, 2'b01, 2'b11, 2'b10, 2'b10, 2'b01,
                                        2'b00, 2'b01, 2'b10, 2'b11, 2'b01, 2'b01, 2'b10, 2'b00};

   logic sys_clk = 1'b0;
   logic sys_rst = 1'b1;
   logic sys_ena = 1'b1;
   logic iwb_ack = 1'b0;
   logic dwb_ack = 1'b0;
   logic xwb_ack = 1'b0;
   pipe_pkg::word_t    iwb_dat = '0;
   logic               iwb_stb, dwb_stb, xwb_stb, gpha;
   pipe_pkg::addr_t    iwb_adr;
   pipe_pkg::bus_req_t dwb_req, xwb_req;

   // Stimulus table and expected bus per row, -1 for no access
   pipe_pkg::word_t word_tab [N];
   int              fetch_dly [N];
   int              bus_dly [N];
   logic            stall_tab [N];
   int              exp_bus_tab [N];
   // Rows expected on a bus, in order
   int              exp_rows [$];

   integer     seed = 22405;
   int         limit = 0;
   int         cycles = 0;
   int         errors = 0;
   int         end_errors = 0;
   int         fetch_idx = 0;
   int         fetch_wait = 0;
   int         stall_cnt = 0;
   int         accesses = 0;
   int         next_exp = 0;
   int         toggles = 0;
   logic       pha_prev = 1'b0;
   logic [1:0] ena_hist = 2'b11;
   logic [1:0] bus_seen = 2'b00;
   int         bus_wait [2] = '{0, 0};
   int         bus_dly_now [2] = '{0, 0};

   pipe_top #(.RESET_ADDR (RESET_ADDR)) pipe_top_i (
      .sys_clk_i (sys_clk), .sys_rst_i (sys_rst), .sys_ena_i (sys_ena),
      .iwb_stb_o (iwb_stb), .iwb_adr_o (iwb_adr), .iwb_ack_i (iwb_ack), .iwb_dat_i (iwb_dat),
      .dwb_stb_o (dwb_stb), .dwb_req_o (dwb_req), .dwb_ack_i (dwb_ack),
      .xwb_stb_o (xwb_stb), .xwb_req_o (xwb_req), .xwb_ack_i (xwb_ack),
      .gpha_o (gpha)
   );

   always #50 sys_clk = ~sys_clk;

   // Enable history, bit 1 is the value at the previous rising edge
   always @(posedge sys_clk) begin
      ena_hist <= {ena_hist[0], sys_ena};
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("Timeout after %0d cycles, the pipeline did not drain", cycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input int row,
                                  input logic [31:0] exp_val, input logic [31:0] act_val);
      errors++;
      $display("[ERROR] %s row %0d: expected %h, actual %h", name, row, exp_val, act_val);
   endtask

   // New strobe on a bus, compared with the next expected row
   task automatic start_access(input int bus, input pipe_pkg::bus_req_t req, output int dly);
      int r;
      dly = 0;
      accesses++;
      // A take needs the enable one edge before the strobe rises
      if (ena_hist[1] !== 1'b1) begin
         errors++;
         $display("Bus access started while sys_ena_i was low");
      end
      if (next_exp >= exp_rows.size()) begin
         errors++;
         $display("Bus access with no table word left to issue");
      end else begin
         r = exp_rows[next_exp];
         next_exp++;
         if (bus != exp_bus_tab[r])
            report_mismatch("route", r, exp_bus_tab[r], bus);
         if (req.adr !== word_tab[r][29:0])
            report_mismatch("req_adr", r, {2'b00, word_tab[r][29:0]}, {2'b00, req.adr});
         // Every row is taken in order, so the phase alternates from 0
         if (req.tid !== r[0])
            report_mismatch("req_tid", r, {31'd0, r[0]}, {31'd0, req.tid});
         if (req.spare !== 1'b0)
            report_mismatch("req_spare", r, 32'd0, {31'd0, req.spare});
         dly = bus_dly[r];
      end
   endtask

   // Responders and monitors, outputs sampled and inputs driven on the falling edge
   always @(negedge sys_clk) begin
      logic [1:0]         stb;
      logic [1:0]         bus_ack;
      pipe_pkg::bus_req_t req [2];
      pipe_pkg::addr_t    exp_adr;
      int                 b;
      stb = {xwb_stb, dwb_stb};
      req[0] = dwb_req;
      req[1] = xwb_req;
      // Stall window
      sys_ena = (stall_cnt == 0);
      if (stall_cnt > 0)
         stall_cnt--;
      // Instruction bus, table words in order
      iwb_ack = 1'b0;
      iwb_dat = '0;
      if (iwb_stb === 1'b1 && fetch_idx < N) begin
         if (fetch_wait == fetch_dly[fetch_idx]) begin
            exp_adr = RESET_ADDR + 30'(fetch_idx);
            if (iwb_adr !== exp_adr)
               report_mismatch("fetch_adr", fetch_idx, {2'b00, exp_adr}, {2'b00, iwb_adr});
            iwb_ack = 1'b1;
            iwb_dat = word_tab[fetch_idx];
            if (stall_tab[fetch_idx])
               stall_cnt = STALL_CYCLES;
            fetch_idx++;
            fetch_wait = 0;
         end else begin
            fetch_wait++;
         end
      end
      // Only one port may hold a request
      if (stb == 2'b11) begin
         errors++;
         $display("Data and extension ports busy at the same time");
      end
      // Data bus is 0, extension bus is 1
      for (b = 0; b < 2; b++) begin
         bus_ack[b] = 1'b0;
         if (stb[b]) begin
            if (!bus_seen[b]) begin
               bus_seen[b] = 1'b1;
               bus_wait[b] = 0;
               start_access(b, req[b], bus_dly_now[b]);
            end
            if (bus_wait[b] == bus_dly_now[b])
               bus_ack[b] = 1'b1;
            bus_wait[b]++;
         end else begin
            bus_seen[b] = 1'b0;
         end
      end
      dwb_ack = bus_ack[0];
      xwb_ack = bus_ack[1];
      // Phase toggles, two during grst then one per taken word
      if (gpha !== pha_prev)
         toggles++;
      pha_prev = gpha;
   end

   initial begin
      int i;
      // Table fill, every fifth row gets a long bus delay
      for (i = 0; i < N; i++) begin
         word_tab[i]  = {KINDS[i], 30'($random(seed))};
         fetch_dly[i] = {$random(seed)} % 4;
         bus_dly[i]   = (i % 5 == 4) ? 12 + {$random(seed)} % 4 : {$random(seed)} % 4;
         stall_tab[i] = (i == 5 || i == 11);
         exp_bus_tab[i] = (KINDS[i] == 2'b01) ? 0 : (KINDS[i] == 2'b10) ? 1 : -1;
         if (exp_bus_tab[i] >= 0)
            exp_rows.push_back(i);
         limit = limit + fetch_dly[i] + bus_dly[i] + 10;
      end
      // Reset for 5 cycles, strobes checked once grst has settled them
      @(negedge sys_clk);
      for (i = 0; i < 6; i++) begin
         @(negedge sys_clk);
         if (i == 3)
            sys_rst = 1'b0;
         if (iwb_stb !== 1'b0 || dwb_stb !== 1'b0 || xwb_stb !== 1'b0) begin
            end_errors++;
            $display("Strobe not low during reset or the two grst clocks");
         end
      end
      // Apply the table row by row
      for (i = 0; i < N; i++) begin
         while (fetch_idx <= i)
            @(negedge sys_clk);
      end
      // Drain the last accesses
      while (next_exp < exp_rows.size() || dwb_stb || xwb_stb || toggles < N + 2)
         @(negedge sys_clk);
      repeat (4) @(negedge sys_clk);
      if (next_exp != exp_rows.size()) begin
         end_errors++;
         $display("Bus accesses missing at the end of the run");
      end
      if (toggles != N + 2) begin
         end_errors++;
         $display("[ERROR] phase_toggles: expected %0d, actual %0d", N + 2, toggles);
      end
      $display("Fetches %0d, bus accesses %0d, monitor errors %0d, end errors %0d",
               fetch_idx, accesses, errors, end_errors);
      if (errors == 0 && end_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: list.f
verilog/pipe_pkg.sv
verilog/pipe_ctrl.sv
verilog/fetch_unit.sv
verilog/issue_stage.sv
verilog/bus_port.sv
verilog/pipe_top.sv
verif/pipe_top_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module pipe_top_tb -o sim_pipe
./obj_dir/sim_pipe > sim.log 2>&1
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
